//--- rtl/sya_pkg.sv
//==========================================================================
// Shared sizes, element and vector types, controller states and the
// layout of the configuration word for the systolic matrix unit
//==========================================================================

package sya_pkg;

    // Array geometry and data widths
    localparam int ARRAY_DIM    = 4;
    localparam int ACT_WIDTH    = 8;
    localparam int CHN_WIDTH    = 16;
    localparam int PSUM_WIDTH   = 2 * ACT_WIDTH + CHN_WIDTH;
    localparam int ADDR_WIDTH   = 16;
    localparam int FLUSH_CYCLES = 2 * ARRAY_DIM - 1;
    localparam int CFG_WIDTH    = 96;

    typedef logic signed [ACT_WIDTH-1:0]  data_t;
    typedef data_t [ARRAY_DIM-1:0]        vec_t;
    typedef logic signed [PSUM_WIDTH-1:0] psum_t;
    typedef logic [ADDR_WIDTH-1:0]        addr_t;
    typedef logic [CHN_WIDTH-1:0]         cnt_t;

    typedef enum logic [1:0] {
        IDLE,
        COMP,
        FLUSH,
        DRAIN
    } sya_state_e;

    // Configuration word, most significant field first
    typedef struct packed {
        addr_t                ofm_base;
        addr_t                act_base;
        addr_t                wgt_base;
        cnt_t                 num_grp;
        cnt_t                 num_chn;
        logic [ACT_WIDTH-1:0] shift;
        logic [ACT_WIDTH-1:0] zp;
    } cfg_t;

endpackage

//--- rtl/sya_cfg_regs.sv
//==========================================================================
// Configuration word capture on the cfg handshake and field registers
//==========================================================================

`timescale 1ns/1ps

module sya_cfg_regs import sya_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic cfg_vld,
    input  cfg_t cfg_info,
    output logic cfg_rdy,
    output cfg_t cfg,
    output logic cfg_load,
    input  logic busy
);

    logic cfg_fire;

    // Not ready while a run is active or just being launched
    assign cfg_rdy  = ~busy & ~cfg_load;
    assign cfg_fire = cfg_vld & cfg_rdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg      <= '{ofm_base: '0, act_base: '0, wgt_base: '0,
                          num_grp: cnt_t'(1), num_chn: cnt_t'(1),
                          shift: '0, zp: '0};
            cfg_load <= 1'b0;
        end else begin
            // One cycle pulse, fields are already stored when it is seen
            cfg_load <= cfg_fire;
            if (cfg_fire) begin
                cfg <= cfg_info;
            end
        end
    end

endmodule

//--- rtl/sya_ctrl.sv
//==========================================================================
// Controller FSM with channel, flush and group counters, read address
// generation and the step, zero feed and drain sequencing of the array
//==========================================================================

`timescale 1ns/1ps

module sya_ctrl import sya_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  cfg_load,
    input  cfg_t  cfg,
    output logic  busy,
    output addr_t act_rd_addr,
    output addr_t wgt_rd_addr,
    output logic  rd_addr_vld,
    input  logic  act_rd_addr_rdy,
    input  logic  wgt_rd_addr_rdy,
    input  logic  act_rd_dat_vld,
    input  logic  wgt_rd_dat_vld,
    output logic  rd_dat_rdy,
    output logic  acc_clr,
    output logic  step,
    output logic  feed_zero,
    output logic  drain_start,
    input  logic  drain_done
);

    sya_state_e state, next_state;
    cnt_t       iss_cnt, con_cnt, flush_cnt, grp_cnt;
    addr_t      grp_off;
    logic       iss_fire, dat_fire;
    logic       last_chn, last_flush, last_grp;

    //==========================================================================
    // Handshakes and array controls
    //==========================================================================
    assign busy        = (state != IDLE);
    assign rd_addr_vld = (state == COMP) && (iss_cnt < cfg.num_chn);
    assign iss_fire    = rd_addr_vld & act_rd_addr_rdy & wgt_rd_addr_rdy;
    assign rd_dat_rdy  = (state == COMP);
    assign dat_fire    = rd_dat_rdy & act_rd_dat_vld & wgt_rd_dat_vld;
    assign feed_zero   = (state == FLUSH);
    assign step        = dat_fire | feed_zero;

    // Group offset replaces a group times channel multiply
    assign act_rd_addr = cfg.act_base + grp_off + iss_cnt;
    assign wgt_rd_addr = cfg.wgt_base + iss_cnt;

    assign last_chn   = (con_cnt == cfg.num_chn - 1'b1);
    assign last_flush = (flush_cnt == cnt_t'(FLUSH_CYCLES - 1));
    assign last_grp   = (grp_cnt == cfg.num_grp - 1'b1);

    //==========================================================================
    // FSM
    //==========================================================================
    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (cfg_load) next_state = COMP;
            COMP:    if (dat_fire && last_chn) next_state = FLUSH;
            FLUSH:   if (last_flush) next_state = DRAIN;
            DRAIN:   if (drain_done) next_state = last_grp ? IDLE : COMP;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            iss_cnt     <= '0;
            con_cnt     <= '0;
            flush_cnt   <= '0;
            grp_cnt     <= '0;
            grp_off     <= '0;
            acc_clr     <= 1'b0;
            drain_start <= 1'b0;
        end else begin
            state       <= next_state;
            acc_clr     <= (next_state == COMP) && (state != COMP);
            drain_start <= (state == FLUSH) && last_flush;

            // Per-phase counters restart whenever their phase is left
            iss_cnt   <= (state != COMP) ? '0 : iss_cnt + cnt_t'(iss_fire);
            con_cnt   <= (state != COMP) ? '0 : con_cnt + cnt_t'(dat_fire);
            flush_cnt <= (state != FLUSH) ? '0 : flush_cnt + 1'b1;

            if (cfg_load) begin
                grp_cnt <= '0;
                grp_off <= '0;
            end else if (state == DRAIN && drain_done && !last_grp) begin
                grp_cnt <= grp_cnt + 1'b1;
                grp_off <= grp_off + cfg.num_chn;
            end
        end
    end

endmodule

//--- rtl/sya_pe.sv
//==========================================================================
// Multiply-accumulate cell, passes activation east and weight south
//==========================================================================

`timescale 1ns/1ps

module sya_pe import sya_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  en,
    input  logic  clr,
    input  data_t act_in,
    input  data_t wgt_in,
    output data_t act_out,
    output data_t wgt_out,
    output psum_t psum
);

    psum_t prod;

    // Operands are sign extended to the accumulator width
    assign prod = act_in * wgt_in;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_out <= '0;
            wgt_out <= '0;
            psum    <= '0;
        end else begin
            if (en) begin
                act_out <= act_in;
                wgt_out <= wgt_in;
            end
            // A step in the clear cycle starts the new sum
            if (clr) begin
                psum <= en ? prod : '0;
            end else if (en) begin
                psum <= psum + prod;
            end
        end
    end

endmodule

//--- rtl/sya_pe_array.sv
//==========================================================================
// Input skew registers and the grid of multiply-accumulate cells
// Activations flow west to east, weights north to south
//==========================================================================

`timescale 1ns/1ps

module sya_pe_array import sya_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  step,
    input  logic  clr,
    input  logic  feed_zero,
    input  vec_t  act_vec,
    input  vec_t  wgt_vec,
    output psum_t [ARRAY_DIM-1:0][ARRAY_DIM-1:0] psum_grid
);

    // Horizontal and vertical links between neighbouring cells
    data_t act_h [ARRAY_DIM][ARRAY_DIM+1];
    data_t wgt_v [ARRAY_DIM+1][ARRAY_DIM];

    //==========================================================================
    // Skew, lane i delays row i activation and column i weight by i steps
    //==========================================================================
    for (genvar i = 0; i < ARRAY_DIM; i++) begin : g_skew
        logic [2*ACT_WIDTH-1:0] lane_in;

        assign lane_in = feed_zero ? '0 : {act_vec[i], wgt_vec[i]};

        if (i == 0) begin : g_direct
            assign {act_h[i][0], wgt_v[0][i]} = lane_in;
        end else begin : g_delay
            logic [2*ACT_WIDTH-1:0] sr [i];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int k = 0; k < i; k++) begin
                        sr[k] <= '0;
                    end
                end else if (step) begin
                    sr[0] <= lane_in;
                    for (int k = 1; k < i; k++) begin
                        sr[k] <= sr[k-1];
                    end
                end
            end

            assign {act_h[i][0], wgt_v[0][i]} = sr[i-1];
        end
    end

    //==========================================================================
    // Cell grid
    //==========================================================================
    for (genvar r = 0; r < ARRAY_DIM; r++) begin : g_row
        for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_col
            sya_pe u_pe (
                .clk     (clk),
                .rst_n   (rst_n),
                .en      (step),
                .clr     (clr),
                .act_in  (act_h[r][c]),
                .wgt_in  (wgt_v[r][c]),
                .act_out (act_h[r][c+1]),
                .wgt_out (wgt_v[r+1][c]),
                .psum    (psum_grid[r][c])
            );
        end
    end

endmodule

//--- rtl/sya_drain.sv
//==========================================================================
// Row drain of the array: row select, ReLU with shift and zero point,
// output row register and the write address counter
//==========================================================================

`timescale 1ns/1ps

module sya_drain import sya_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  psum_t [ARRAY_DIM-1:0][ARRAY_DIM-1:0] psum_grid,
    input  cfg_t  cfg,
    input  logic  cfg_load,
    input  logic  drain_start,
    output logic  drain_done,
    output vec_t  ofm_wr_dat,
    output addr_t ofm_wr_addr,
    output logic  ofm_wr_vld,
    input  logic  ofm_wr_rdy
);

    logic [$clog2(ARRAY_DIM)-1:0] row_cnt, row_nxt;
    logic wr_fire, last_row, row_load;
    vec_t rq_row;

    // Negative sums clamp to zero, others take 8 bits from bit shift up
    function automatic data_t requant(input psum_t p, input logic [ACT_WIDTH-1:0] sh,
                                      input logic [ACT_WIDTH-1:0] zp);
        psum_t shifted;
        shifted = p >> sh;
        if (p[PSUM_WIDTH-1]) begin
            return '0;
        end
        return data_t'(shifted[ACT_WIDTH-1:0] + zp);
    endfunction

    assign wr_fire    = ofm_wr_vld & ofm_wr_rdy;
    assign last_row   = (row_cnt == ARRAY_DIM - 1);
    assign drain_done = wr_fire & last_row;
    assign row_load   = drain_start | (wr_fire & ~last_row);
    assign row_nxt    = drain_start ? '0 : row_cnt + 1'b1;

    always_comb begin
        for (int c = 0; c < ARRAY_DIM; c++) begin
            rq_row[c] = requant(psum_grid[row_nxt][c], cfg.shift, cfg.zp);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ofm_wr_vld  <= 1'b0;
            row_cnt     <= '0;
            ofm_wr_addr <= '0;
        end else begin
            if (drain_start) begin
                ofm_wr_vld <= 1'b1;
            end else if (drain_done) begin
                ofm_wr_vld <= 1'b0;
            end
            if (row_load) begin
                row_cnt <= row_nxt;
            end
            // Address runs on across groups of one configuration
            if (cfg_load) begin
                ofm_wr_addr <= cfg.ofm_base;
            end else if (wr_fire) begin
                ofm_wr_addr <= ofm_wr_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (row_load) begin
            ofm_wr_dat <= rq_row;
        end
    end

endmodule

//--- rtl/sya_top.sv
//==========================================================================
// Systolic matrix unit top: configuration registers, controller,
// cell array and drain, with buffer read and write ports
//==========================================================================

`timescale 1ns/1ps

module sya_top import sya_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    // Configuration
    input  logic  cfg_vld,
    output logic  cfg_rdy,
    input  cfg_t  cfg_info,
    // Activation read
    output addr_t act_rd_addr,
    output logic  act_rd_addr_vld,
    input  logic  act_rd_addr_rdy,
    input  vec_t  act_rd_dat,
    input  logic  act_rd_dat_vld,
    output logic  act_rd_dat_rdy,
    // Weight read
    output addr_t wgt_rd_addr,
    output logic  wgt_rd_addr_vld,
    input  logic  wgt_rd_addr_rdy,
    input  vec_t  wgt_rd_dat,
    input  logic  wgt_rd_dat_vld,
    output logic  wgt_rd_dat_rdy,
    // Output feature map write
    output vec_t  ofm_wr_dat,
    output addr_t ofm_wr_addr,
    output logic  ofm_wr_vld,
    input  logic  ofm_wr_rdy
);

    cfg_t  cfg;
    logic  cfg_load, busy;
    logic  rd_addr_vld, rd_dat_rdy;
    logic  acc_clr, step, feed_zero;
    logic  drain_start, drain_done;
    psum_t [ARRAY_DIM-1:0][ARRAY_DIM-1:0] psum_grid;

    // Both read channels move in lock step
    assign act_rd_addr_vld = rd_addr_vld;
    assign wgt_rd_addr_vld = rd_addr_vld;
    assign act_rd_dat_rdy  = rd_dat_rdy;
    assign wgt_rd_dat_rdy  = rd_dat_rdy;

    sya_cfg_regs u_cfg_regs (
        .clk      (clk),      .rst_n    (rst_n),
        .cfg_vld  (cfg_vld),  .cfg_info (cfg_info),
        .cfg_rdy  (cfg_rdy),  .cfg      (cfg),
        .cfg_load (cfg_load), .busy     (busy)
    );

    sya_ctrl u_ctrl (
        .clk             (clk),             .rst_n           (rst_n),
        .cfg_load        (cfg_load),        .cfg             (cfg),
        .busy            (busy),            .act_rd_addr     (act_rd_addr),
        .wgt_rd_addr     (wgt_rd_addr),     .rd_addr_vld     (rd_addr_vld),
        .act_rd_addr_rdy (act_rd_addr_rdy), .wgt_rd_addr_rdy (wgt_rd_addr_rdy),
        .act_rd_dat_vld  (act_rd_dat_vld),  .wgt_rd_dat_vld  (wgt_rd_dat_vld),
        .rd_dat_rdy      (rd_dat_rdy),      .acc_clr         (acc_clr),
        .step            (step),            .feed_zero       (feed_zero),
        .drain_start     (drain_start),     .drain_done      (drain_done)
    );

    sya_pe_array u_pe_array (
        .clk       (clk),        .rst_n     (rst_n),
        .step      (step),       .clr       (acc_clr),
        .feed_zero (feed_zero),  .act_vec   (act_rd_dat),
        .wgt_vec   (wgt_rd_dat), .psum_grid (psum_grid)
    );

    sya_drain u_drain (
        .clk         (clk),         .rst_n       (rst_n),
        .psum_grid   (psum_grid),   .cfg         (cfg),
        .cfg_load    (cfg_load),    .drain_start (drain_start),
        .drain_done  (drain_done),  .ofm_wr_dat  (ofm_wr_dat),
        .ofm_wr_addr (ofm_wr_addr), .ofm_wr_vld  (ofm_wr_vld),
        .ofm_wr_rdy  (ofm_wr_rdy)
    );

endmodule

//--- testbench/sya_assertions.sv
//==========================================================================
// Concurrent checks on the handshakes of the systolic unit top level,
// bound into sya_top from the testbench
//==========================================================================

`timescale 1ns/1ps

module sya_assertions import sya_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       cfg_rdy,
    input logic       act_rd_addr_vld,
    input logic       wgt_rd_addr_vld,
    input logic       ofm_wr_vld,
    input logic       ofm_wr_rdy,
    input vec_t       ofm_wr_dat,
    input addr_t      ofm_wr_addr,
    input sya_state_e state
);

    // Read by the testbench at the end of the run
    int fail_count = 0;

    // Quiet outputs in reset and on the first cycle out of it
    a_reset_quiet: assert property (@(posedge clk)
        (!rst_n || $rose(rst_n)) |-> !ofm_wr_vld && !act_rd_addr_vld && !wgt_rd_addr_vld)
        else begin
            $error("write or address valid high around reset");
            fail_count++;
        end

    // Stalled write keeps its row and address
    a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ofm_wr_vld && !ofm_wr_rdy |=>
            ofm_wr_vld && $stable(ofm_wr_dat) && $stable(ofm_wr_addr))
        else begin
            $error("ofm write changed while stalled");
            fail_count++;
        end

    a_cfg_busy: assert property (@(posedge clk) disable iff (!rst_n)
        state != IDLE |-> !cfg_rdy)
        else begin
            $error("cfg_rdy high outside IDLE");
            fail_count++;
        end

    a_addr_pair: assert property (@(posedge clk) disable iff (!rst_n)
        act_rd_addr_vld == wgt_rd_addr_vld)
        else begin
            $error("activation and weight address valids differ");
            fail_count++;
        end

endmodule

//--- testbench/sya_tb.sv
//==========================================================================
// Testbench for the systolic matrix unit: clock, reset, buffer model,
// reference rows, configuration runs, output checks and watchdog
//==========================================================================

`timescale 1ns/1ps

module sya_tb import sya_pkg::*; ();

    localparam int MEM_DEPTH = 1024;
    localparam int NUM_TESTS = 4;

    logic  clk = 1'b0;
    logic  rst_n;
    logic  cfg_vld, cfg_rdy;
    cfg_t  cfg_info;
    addr_t act_rd_addr, wgt_rd_addr, ofm_wr_addr;
    logic  act_rd_addr_vld, act_rd_addr_rdy, act_rd_dat_vld, act_rd_dat_rdy;
    logic  wgt_rd_addr_vld, wgt_rd_addr_rdy, wgt_rd_dat_vld, wgt_rd_dat_rdy;
    vec_t  act_rd_dat, wgt_rd_dat, ofm_wr_dat;
    logic  ofm_wr_vld, ofm_wr_rdy;

    int    seed;
    vec_t  act_mem [MEM_DEPTH];
    vec_t  wgt_mem [MEM_DEPTH];
    addr_t act_q[$];
    addr_t wgt_q[$];
    int    due_q[$];
    cfg_t  tests [NUM_TESTS];
    bit    stall_of [NUM_TESTS];
    cfg_t  cur_cfg;
    bit    stall_en, run_active, rdy_due;
    int    cyc, rd_grp, rd_chn, wr_cnt, budget_cycles;

    sya_top u_sya_top (.*);

    bind sya_top sya_assertions u_sya_assertions (
        .clk             (clk),             .rst_n           (rst_n),
        .cfg_rdy         (cfg_rdy),         .act_rd_addr_vld (act_rd_addr_vld),
        .wgt_rd_addr_vld (wgt_rd_addr_vld), .ofm_wr_vld      (ofm_wr_vld),
        .ofm_wr_rdy      (ofm_wr_rdy),      .ofm_wr_dat      (ofm_wr_dat),
        .ofm_wr_addr     (ofm_wr_addr),     .state           (u_ctrl.state)
    );

    always #50 clk = ~clk;

    //==========================================================================
    // Checks and reference
    //==========================================================================
    task automatic fail_now(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_row(input vec_t got, input vec_t exp, input string what);
        if (got !== exp) begin
            fail_now($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            fail_now($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_state_idle();
        if (u_sya_top.u_ctrl.state != IDLE || cfg_rdy !== 1'b1) begin
            fail_now("unit not idle with cfg_rdy high");
        end
        if ({act_rd_addr_vld, wgt_rd_addr_vld, ofm_wr_vld,
             act_rd_dat_rdy, wgt_rd_dat_rdy} !== '0) begin
            fail_now("valid or data ready output high while idle");
        end
    endtask

    // Row of the output for one group, ReLU then shift and zero point
    function automatic vec_t ref_row(input cfg_t c, input int grp, input int row);
        vec_t res;
        vec_t a;
        vec_t w;
        int   acc;
        int   q;
        for (int col = 0; col < ARRAY_DIM; col++) begin
            acc = 0;
            for (int k = 0; k < c.num_chn; k++) begin
                a = act_mem[(c.act_base + grp * c.num_chn + k) % MEM_DEPTH];
                w = wgt_mem[(c.wgt_base + k) % MEM_DEPTH];
                acc += $signed(a[row]) * $signed(w[col]);
            end
            if (acc < 0) begin
                res[col] = '0;
            end else begin
                q = (acc >> c.shift) + c.zp;
                res[col] = data_t'(q & 8'hff);
            end
        end
        return res;
    endfunction

    // Positive activations, columns 2 and 3 get negative weights
    task automatic make_signed_data(input int act_base, input int wgt_base, input int n);
        for (int k = 0; k < n; k++) begin
            for (int e = 0; e < ARRAY_DIM; e++) begin
                act_mem[act_base + k][e] = data_t'($random(seed) & 8'h7f);
                if (e < 2) begin
                    wgt_mem[wgt_base + k][e] = data_t'($random(seed) & 8'h3f);
                end else begin
                    wgt_mem[wgt_base + k][e] = data_t'(-1 - ($random(seed) & 8'h3f));
                end
            end
        end
    endtask

    //==========================================================================
    // Buffer model and compare process
    //==========================================================================
    always @(negedge clk) begin
        if (stall_en) begin
            act_rd_addr_rdy = ($random(seed) & 3) != 0;
            wgt_rd_addr_rdy = ($random(seed) & 3) != 0;
            ofm_wr_rdy      = ($random(seed) & 1) != 0;
        end else begin
            act_rd_addr_rdy = 1'b1;
            wgt_rd_addr_rdy = 1'b1;
            ofm_wr_rdy      = 1'b1;
        end
        // Oldest request answers once its delay has passed
        if (due_q.size() > 0 && due_q[0] <= cyc) begin
            act_rd_dat_vld = 1'b1;
            wgt_rd_dat_vld = 1'b1;
            act_rd_dat     = act_mem[act_q[0] % MEM_DEPTH];
            wgt_rd_dat     = wgt_mem[wgt_q[0] % MEM_DEPTH];
        end else begin
            act_rd_dat_vld = 1'b0;
            wgt_rd_dat_vld = 1'b0;
        end
    end

    always @(posedge clk) begin
        addr_t exp_act;
        int    grp;
        cyc++;
        if (rdy_due) begin
            if (cfg_rdy !== 1'b1) begin
                fail_now("cfg_rdy not high on the cycle after the last write");
            end
            rdy_due    = 1'b0;
            run_active = 1'b0;
        end else if (run_active && cfg_rdy) begin
            fail_now("cfg_rdy rose before the last write");
        end
        if (cfg_vld && cfg_rdy) begin
            run_active = 1'b1;
        end
        if (act_rd_addr_vld && act_rd_addr_rdy && wgt_rd_addr_rdy) begin
            if (rd_grp >= cur_cfg.num_grp) begin
                fail_now("read address issued after the last group");
            end
            exp_act = cur_cfg.act_base + rd_grp * cur_cfg.num_chn + rd_chn;
            check_addr(act_rd_addr, exp_act, "activation read address");
            check_addr(wgt_rd_addr, cur_cfg.wgt_base + rd_chn, "weight read address");
            act_q.push_back(act_rd_addr);
            wgt_q.push_back(wgt_rd_addr);
            due_q.push_back(cyc + (stall_en ? ($random(seed) & 7) : 2));
            rd_chn++;
            if (rd_chn == cur_cfg.num_chn) begin
                rd_chn = 0;
                rd_grp++;
            end
        end
        if (act_rd_dat_vld && act_rd_dat_rdy && wgt_rd_dat_rdy) begin
            void'(act_q.pop_front());
            void'(wgt_q.pop_front());
            void'(due_q.pop_front());
        end
        if (ofm_wr_vld && ofm_wr_rdy) begin
            if (!run_active || wr_cnt >= cur_cfg.num_grp * ARRAY_DIM) begin
                fail_now("unexpected ofm write");
            end
            grp = wr_cnt / ARRAY_DIM;
            check_addr(ofm_wr_addr, cur_cfg.ofm_base + wr_cnt, "ofm write address");
            check_row(ofm_wr_dat, ref_row(cur_cfg, grp, wr_cnt % ARRAY_DIM), "ofm row");
            wr_cnt++;
            rdy_due = (wr_cnt == cur_cfg.num_grp * ARRAY_DIM);
        end
    end

    //==========================================================================
    // Stimulus
    //==========================================================================
    task automatic run_config(input cfg_t c);
        @(negedge clk);
        cur_cfg  = c;
        rd_grp   = 0;
        rd_chn   = 0;
        wr_cnt   = 0;
        cfg_info = c;
        cfg_vld  = 1'b1;
        do @(posedge clk); while (!cfg_rdy);
        @(negedge clk);
        cfg_vld  = 1'b0;
        cfg_info = '0;
        do @(negedge clk); while (run_active || rdy_due);
        if (rd_grp != c.num_grp || rd_chn != 0 || act_q.size() != 0) begin
            fail_now("read requests missing or unanswered at end of run");
        end
        check_state_idle();
    endtask

    initial begin
        int budget;
        seed            = 32'hab976bb5;
        rst_n           = 1'b0;
        cfg_vld         = 1'b0;
        cfg_info        = '0;
        act_rd_addr_rdy = 1'b0;
        wgt_rd_addr_rdy = 1'b0;
        act_rd_dat      = '0;
        wgt_rd_dat      = '0;
        act_rd_dat_vld  = 1'b0;
        wgt_rd_dat_vld  = 1'b0;
        ofm_wr_rdy      = 1'b0;
        stall_en        = 1'b0;
        run_active      = 1'b0;
        rdy_due         = 1'b0;
        cyc             = 0;
        cur_cfg         = '0;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            act_mem[i] = $random(seed);
            wgt_mem[i] = $random(seed);
        end
        make_signed_data(16'h0080, 16'h0180, 8);

        tests[0] = '{ofm_base: 16'h0300, act_base: 16'h0000, wgt_base: 16'h0100,
                     num_grp: 16'd1, num_chn: 16'd5, shift: 8'd0, zp: 8'd0};
        tests[1] = '{ofm_base: 16'h0310, act_base: 16'h0020, wgt_base: 16'h0110,
                     num_grp: 16'd3, num_chn: 16'd6, shift: 8'd4, zp: 8'd3};
        tests[2] = '{ofm_base: 16'h0320, act_base: 16'h0080, wgt_base: 16'h0180,
                     num_grp: 16'd1, num_chn: 16'd8, shift: 8'd6, zp: 8'h15};
        tests[3] = '{ofm_base: 16'h0330, act_base: 16'h0040, wgt_base: 16'h0120,
                     num_grp: 16'd2, num_chn: 16'd7, shift: 8'd3, zp: 8'hf0};
        stall_of = '{1'b0, 1'b0, 1'b0, 1'b1};

        budget = 10 + 200;
        for (int t = 0; t < NUM_TESTS; t++) begin
            budget += tests[t].num_grp * (tests[t].num_chn + FLUSH_CYCLES + ARRAY_DIM) * 8;
        end
        budget_cycles = budget;

        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_state_idle();

        for (int t = 0; t < NUM_TESTS; t++) begin
            stall_en = stall_of[t];
            run_config(tests[t]);
        end

        if (u_sya_top.u_sya_assertions.fail_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("[FAIL] %0t ns: %0d assertion failures", $time,
                     u_sya_top.u_sya_assertions.fail_count);
            $display("TEST FAILED");
            $fatal(1, "assertion failures");
        end
    end

    // Watchdog sized from the configured runs
    initial begin
        wait (budget_cycles > 0);
        repeat (budget_cycles) @(posedge clk);
        $display("Watchdog timeout: the run did not finish within %0d cycles", budget_cycles);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

endmodule

//--- files.f
rtl/sya_pkg.sv
rtl/sya_cfg_regs.sv
rtl/sya_ctrl.sv
rtl/sya_pe.sv
rtl/sya_pe_array.sv
rtl/sya_drain.sv
rtl/sya_top.sv
testbench/sya_assertions.sv
testbench/sya_tb.sv

//--- Bender.yml
package:
  name: sya

sources:
  - files:
      - rtl/sya_pkg.sv
      - rtl/sya_cfg_regs.sv
      - rtl/sya_ctrl.sv
      - rtl/sya_pe.sv
      - rtl/sya_pe_array.sv
      - rtl/sya_drain.sv
      - rtl/sya_top.sv
  - target: test
    files:
      - testbench/sya_assertions.sv
      - testbench/sya_tb.sv
